/* design/xgmii_rx_pkg.sv */
// shared by all rx blocks; lane-0 start only, CRC constants are for the reflected IEEE 802.3 CRC-32
package xgmii_rx_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------

    // one xgmii or stream data word
    typedef logic [63:0] xgmii_data_t;

    // xgmii control lanes, also the tkeep mask
    typedef logic [7:0] xgmii_ctrl_t;

    // crc register value
    typedef logic [31:0] crc_t;

    // byte lane index within a word
    typedef logic [2:0] lane_t;

    // frame counters, wrap on overflow
    typedef logic [31:0] frame_cnt_t;

    // ----------------------------------------
    // framer states
    // ----------------------------------------

    typedef enum logic [1:0] {
        // waiting for a start word
        RX_IDLE  = 2'd0,
        // first data word, nothing emitted yet
        RX_FIRST = 2'd1,
        // a word is held and the frame goes on
        RX_DATA  = 2'd2,
        // extra tail beat, terminate in lanes 5 to 7
        RX_FIN   = 2'd3
    } rx_state_t;

    // ----------------------------------------
    // xgmii characters
    // ----------------------------------------

    localparam logic [7:0] XGMII_START    = 8'hFB;
    localparam logic [7:0] XGMII_TERM     = 8'hFD;
    localparam logic [7:0] XGMII_IDLE     = 8'h07;
    localparam logic [7:0] XGMII_PREAMBLE = 8'h55;
    localparam logic [7:0] XGMII_SFD      = 8'hD5;

    // ----------------------------------------
    // crc-32
    // ----------------------------------------

    // reflected 802.3 polynomial
    localparam crc_t CRC_POLY_REFL = 32'hEDB88320;
    localparam crc_t CRC_PRESET    = 32'hFFFFFFFF;
    // register value after payload plus a correct fcs
    localparam crc_t CRC_RESIDUE   = 32'hDEBB20E3;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    localparam int BYTES_PER_WORD = 8;
    localparam int FCS_BYTES      = 4;

endpackage

/* design/xgmii_ctrl_decode.sv */
// purely combinational; only a lane-0 start word is recognized, idles above a terminate are not checked
module xgmii_ctrl_decode (
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_c_i,
    output logic                      start_o,
    output logic                      data_o,
    output logic                      term_o,
    output xgmii_rx_pkg::lane_t       term_lane_o,
    output logic                      ctrl_err_o
);
    import xgmii_rx_pkg::*;

    // full start word, byte 0 first on the wire
    localparam xgmii_data_t START_WORD = {XGMII_SFD, {6{XGMII_PREAMBLE}}, XGMII_START};

    lane_t       first_lane;
    xgmii_ctrl_t upper_mask;
    logic [7:0]  lane_char;
    logic        any_ctrl;
    logic        upper_ok;

    // ----------------------------------------
    // lowest control lane
    // ----------------------------------------

    // scan downwards so the lowest set bit wins
    always_comb begin
        first_lane = '0;
        for (int i = BYTES_PER_WORD - 1; i >= 0; i--) begin
            if (xgmii_c_i[i]) begin
                first_lane = lane_t'(i);
            end
        end
    end

    // every lane from the first control lane up must be control
    assign upper_mask = xgmii_ctrl_t'(8'hFF << first_lane);
    assign upper_ok   = (xgmii_c_i == upper_mask);
    assign any_ctrl   = |xgmii_c_i;

    // character sitting in that lane
    assign lane_char = xgmii_d_i[{first_lane, 3'b000} +: 8];

    // ----------------------------------------
    // word classes
    // ----------------------------------------

    assign data_o  = ~any_ctrl;
    assign start_o = (xgmii_c_i == 8'h01) && (xgmii_d_i == START_WORD);

    assign term_o      = any_ctrl && upper_ok && (lane_char == XGMII_TERM);
    assign term_lane_o = first_lane;

    // idle words also land here; the framer ignores it outside a frame
    assign ctrl_err_o = any_ctrl && ~term_o;

endmodule

/* design/crc32_d64.sv */
// combinational, one full byte chain per lane; long path when all 8 bytes are folded in one cycle
module crc32_d64 (
    input  xgmii_rx_pkg::crc_t        crc_i,
    input  xgmii_rx_pkg::xgmii_data_t data_i,
    input  logic [3:0]                nbytes_i,
    output xgmii_rx_pkg::crc_t        crc_o
);
    import xgmii_rx_pkg::*;

    // ----------------------------------------
    // byte-serial reflected update
    // ----------------------------------------

    // bytes go in from lane 0 upwards, each one lsb first
    always_comb begin
        crc_t crc_v;
        crc_v = crc_i;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            // lanes at and above the count are skipped
            if (4'(b) < nbytes_i) begin
                for (int k = 0; k < 8; k++) begin
                    if (crc_v[0] ^ data_i[8*b + k]) begin
                        crc_v = (crc_v >> 1) ^ CRC_POLY_REFL;
                    end else begin
                        crc_v = crc_v >> 1;
                    end
                end
            end
        end
        crc_o = crc_v;
    end

endmodule

/* design/xgmii_rx_framer.sv */
// lane-0 start only; frames need two full data words, no back-pressure, a start inside a frame aborts it
module xgmii_rx_framer (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  logic                      start_i,
    input  logic                      data_i,
    input  logic                      term_i,
    input  logic                      ctrl_err_i,
    input  xgmii_rx_pkg::lane_t       term_lane_i,
    input  xgmii_rx_pkg::crc_t        crc_next_i,
    output xgmii_rx_pkg::crc_t        crc_o,
    output logic [3:0]                crc_nbytes_o,
    output logic                      beat_valid_o,
    output logic                      beat_last_o,
    output logic                      beat_good_o,
    output xgmii_rx_pkg::xgmii_data_t beat_data_o,
    output xgmii_rx_pkg::xgmii_ctrl_t beat_keep_o
);
    import xgmii_rx_pkg::*;

    rx_state_t   state_q;
    crc_t        crc_q;
    xgmii_data_t held_q;

    // tail beat for a terminate in lanes 5 to 7
    xgmii_data_t tail_data_q;
    xgmii_ctrl_t tail_keep_q;
    logic        tail_good_q;

    logic        beat_valid_q;
    logic        beat_last_q;
    logic        beat_good_q;
    xgmii_data_t beat_data_q;
    xgmii_ctrl_t beat_keep_q;

    logic [3:0]  lane_n;
    logic        in_frame;
    logic        frame_ok;

    // mask of the low n bytes, n from 0 to 8
    function automatic xgmii_ctrl_t keep_low(input logic [3:0] n);
        return xgmii_ctrl_t'(8'hFF >> (4'(BYTES_PER_WORD) - n));
    endfunction

    // ----------------------------------------
    // crc feed
    // ----------------------------------------

    assign lane_n   = {1'b0, term_lane_i};
    assign in_frame = (state_q == RX_FIRST) || (state_q == RX_DATA);

    // the fcs goes through the crc too, so a terminate feeds all k bytes before it
    always_comb begin
        crc_nbytes_o = 4'd0;
        if (in_frame) begin
            if (data_i) begin
                crc_nbytes_o = 4'(BYTES_PER_WORD);
            end else if (term_i) begin
                crc_nbytes_o = lane_n;
            end
        end
    end

    assign crc_o = crc_q;

    // residue check plus a well formed terminate
    assign frame_ok = term_i && (crc_next_i == CRC_RESIDUE);

    // ----------------------------------------
    // state machine and beat builder
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            state_q      <= RX_IDLE;
            crc_q        <= CRC_PRESET;
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= 1'b0;
            beat_last_q  <= 1'b0;
            beat_good_q  <= 1'b0;

            case (state_q)
                RX_IDLE: begin
                    crc_q <= CRC_PRESET;
                    if (start_i) begin
                        state_q <= RX_FIRST;
                    end
                end

                RX_FIRST: begin
                    if (data_i) begin
                        held_q  <= xgmii_d_i;
                        crc_q   <= crc_next_i;
                        state_q <= RX_DATA;
                    end else begin
                        // too short, nothing held yet so nothing to flush
                        crc_q   <= CRC_PRESET;
                        state_q <= start_i ? RX_FIRST : RX_IDLE;
                    end
                end

                RX_DATA: begin
                    if (data_i) begin
                        beat_valid_q <= 1'b1;
                        beat_data_q  <= held_q;
                        beat_keep_q  <= '1;
                        held_q       <= xgmii_d_i;
                        crc_q        <= crc_next_i;
                    end else if (term_i) begin
                        beat_valid_q <= 1'b1;
                        beat_data_q  <= held_q;
                        if (term_lane_i <= lane_t'(FCS_BYTES)) begin
                            // fcs starts inside the held word, it is the last beat
                            beat_keep_q <= keep_low(lane_n + 4'(FCS_BYTES));
                            beat_last_q <= 1'b1;
                            beat_good_q <= frame_ok;
                            state_q     <= RX_IDLE;
                        end else begin
                            // payload spills into the terminate word
                            beat_keep_q <= '1;
                            tail_data_q <= xgmii_d_i;
                            tail_keep_q <= keep_low(lane_n - 4'(FCS_BYTES));
                            tail_good_q <= frame_ok;
                            state_q     <= RX_FIN;
                        end
                    end else if (start_i || ctrl_err_i) begin
                        // flush what we have and mark it bad
                        beat_valid_q <= 1'b1;
                        beat_data_q  <= held_q;
                        beat_keep_q  <= '1;
                        beat_last_q  <= 1'b1;
                        beat_good_q  <= 1'b0;
                        state_q      <= RX_IDLE;
                    end
                end

                RX_FIN: begin
                    beat_valid_q <= 1'b1;
                    beat_data_q  <= tail_data_q;
                    beat_keep_q  <= tail_keep_q;
                    beat_last_q  <= 1'b1;
                    beat_good_q  <= tail_good_q;
                    crc_q        <= CRC_PRESET;
                    // a start right after the terminate word is still caught
                    state_q      <= start_i ? RX_FIRST : RX_IDLE;
                end

                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    assign beat_valid_o = beat_valid_q;
    assign beat_last_o  = beat_last_q;
    assign beat_good_o  = beat_good_q;
    assign beat_data_o  = beat_data_q;
    assign beat_keep_o  = beat_keep_q;

endmodule

/* design/axis_rx_output.sv */
// registered stream outputs without tready; counters wrap and are updated with the last beat
module axis_rx_output (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  logic                      beat_valid_i,
    input  logic                      beat_last_i,
    input  logic                      beat_good_i,
    input  xgmii_rx_pkg::xgmii_data_t beat_data_i,
    input  xgmii_rx_pkg::xgmii_ctrl_t beat_keep_i,
    output xgmii_rx_pkg::xgmii_data_t m_axis_tdata_o,
    output xgmii_rx_pkg::xgmii_ctrl_t m_axis_tkeep_o,
    output logic                      m_axis_tvalid_o,
    output logic                      m_axis_tlast_o,
    output logic                      m_axis_tuser_o,
    output xgmii_rx_pkg::frame_cnt_t  good_frames_o,
    output xgmii_rx_pkg::frame_cnt_t  bad_frames_o
);
    import xgmii_rx_pkg::*;

    frame_cnt_t good_q;
    frame_cnt_t bad_q;
    logic       frame_end;

    assign frame_end = beat_valid_i && beat_last_i;

    // ----------------------------------------
    // stream register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            m_axis_tvalid_o <= 1'b0;
        end else begin
            m_axis_tvalid_o <= beat_valid_i;
            m_axis_tdata_o  <= beat_data_i;
            m_axis_tkeep_o  <= beat_keep_i;
            m_axis_tlast_o  <= beat_last_i;
            // verdict from the framer, raised only with a last beat
            m_axis_tuser_o  <= beat_good_i;
        end
    end

    // ----------------------------------------
    // frame counters
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            good_q <= '0;
            bad_q  <= '0;
        end else if (frame_end) begin
            if (beat_good_i) begin
                good_q <= good_q + 1'b1;
            end else begin
                bad_q <= bad_q + 1'b1;
            end
        end
    end

    assign good_frames_o = good_q;
    assign bad_frames_o  = bad_q;

endmodule

/* design/xgmii2axis_rx.sv */
// xgmii rx to axi-stream, single clock, lane-0 start only, no back-pressure on the stream
module xgmii2axis_rx (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_c_i,
    output xgmii_rx_pkg::xgmii_data_t m_axis_tdata_o,
    output xgmii_rx_pkg::xgmii_ctrl_t m_axis_tkeep_o,
    output logic                      m_axis_tvalid_o,
    output logic                      m_axis_tlast_o,
    output logic                      m_axis_tuser_o,
    output xgmii_rx_pkg::frame_cnt_t  good_frames_o,
    output xgmii_rx_pkg::frame_cnt_t  bad_frames_o
);
    import xgmii_rx_pkg::*;

    // decoder flags for the current word
    logic        start;
    logic        data_word;
    logic        term;
    logic        ctrl_err;
    lane_t       term_lane;

    // crc loop between framer and crc unit
    crc_t        crc_cur;
    crc_t        crc_next;
    logic [3:0]  crc_nbytes;

    // framer to output stage
    logic        beat_valid;
    logic        beat_last;
    logic        beat_good;
    xgmii_data_t beat_data;
    xgmii_ctrl_t beat_keep;

    xgmii_ctrl_decode u_decode (
        .xgmii_d_i   (xgmii_d_i),
        .xgmii_c_i   (xgmii_c_i),
        .start_o     (start),
        .data_o      (data_word),
        .term_o      (term),
        .term_lane_o (term_lane),
        .ctrl_err_o  (ctrl_err)
    );

    crc32_d64 u_crc (
        .crc_i    (crc_cur),
        .data_i   (xgmii_d_i),
        .nbytes_i (crc_nbytes),
        .crc_o    (crc_next)
    );

    xgmii_rx_framer u_framer (
        .clk          (clk),
        .inv_aresetn  (inv_aresetn),
        .xgmii_d_i    (xgmii_d_i),
        .start_i      (start),
        .data_i       (data_word),
        .term_i       (term),
        .ctrl_err_i   (ctrl_err),
        .term_lane_i  (term_lane),
        .crc_next_i   (crc_next),
        .crc_o        (crc_cur),
        .crc_nbytes_o (crc_nbytes),
        .beat_valid_o (beat_valid),
        .beat_last_o  (beat_last),
        .beat_good_o  (beat_good),
        .beat_data_o  (beat_data),
        .beat_keep_o  (beat_keep)
    );

    axis_rx_output u_output (
        .clk             (clk),
        .inv_aresetn     (inv_aresetn),
        .beat_valid_i    (beat_valid),
        .beat_last_i     (beat_last),
        .beat_good_i     (beat_good),
        .beat_data_i     (beat_data),
        .beat_keep_i     (beat_keep),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tkeep_o  (m_axis_tkeep_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tuser_o  (m_axis_tuser_o),
        .good_frames_o   (good_frames_o),
        .bad_frames_o    (bad_frames_o)
    );

endmodule

/* verification/xgmii2axis_rx_assert.sv */
// bound to the rx top level; needs concurrent assertion support, fail_count is read by the testbench
module xgmii2axis_rx_assert (
    input logic                      clk,
    input logic                      inv_aresetn,
    input logic                      tvalid_i,
    input logic                      tlast_i,
    input logic                      tuser_i,
    input xgmii_rx_pkg::xgmii_ctrl_t tkeep_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // stream register is cleared by reset
    a_valid_after_reset: assert property (@(posedge clk) inv_aresetn |=> !tvalid_i)
        else begin
            $error("tvalid high in the cycle after a reset cycle");
            fail_count++;
        end

    // keep starts at byte 0 with no holes
    a_keep_contiguous: assert property (@(posedge clk) disable iff (inv_aresetn)
        tvalid_i |-> (tkeep_i != 8'h00) && (((tkeep_i + 8'h01) & tkeep_i) == 8'h00))
        else begin
            $error("tkeep empty or not contiguous from byte 0");
            fail_count++;
        end

    a_full_keep_mid: assert property (@(posedge clk) disable iff (inv_aresetn)
        tvalid_i && !tlast_i |-> tkeep_i == 8'hFF)
        else begin
            $error("partial tkeep on a beat that is not last");
            fail_count++;
        end

    // verdict only rides on the last beat
    a_user_on_last: assert property (@(posedge clk) disable iff (inv_aresetn)
        tvalid_i && !tlast_i |-> !tuser_i)
        else begin
            $error("tuser high on a beat that is not last");
            fail_count++;
        end

endmodule

bind xgmii2axis_rx xgmii2axis_rx_assert u_rx_assert (
    .clk         (clk),
    .inv_aresetn (inv_aresetn),
    .tvalid_i    (m_axis_tvalid_o),
    .tlast_i     (m_axis_tlast_o),
    .tuser_i     (m_axis_tuser_o),
    .tkeep_i     (m_axis_tkeep_o)
);

/* verification/tb_xgmii2axis_rx.sv */
// directed tests only; frames of at least 60 payload bytes, stops at the first mismatch
module tb_xgmii2axis_rx;
    timeunit 1ns;
    timeprecision 1ps;
    import xgmii_rx_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam logic [15:0] LFSR_SEED      = 16'd65;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;
    localparam logic [7:0]  XGMII_ERROR    = 8'hFE;

    logic        clk;
    logic        inv_aresetn;
    xgmii_data_t xgmii_d;
    xgmii_ctrl_t xgmii_c;
    xgmii_data_t m_axis_tdata;
    xgmii_ctrl_t m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tuser;
    frame_cnt_t  good_frames;
    frame_cnt_t  bad_frames;

    logic [15:0] lfsr;
    int          exp_good;
    int          exp_bad;

    // expected and captured beats
    xgmii_data_t exp_data[$];
    xgmii_ctrl_t exp_keep[$];
    logic        exp_last[$];
    logic        exp_user[$];
    xgmii_data_t cap_data[$];
    xgmii_ctrl_t cap_keep[$];
    logic        cap_last[$];
    logic        cap_user[$];

    xgmii2axis_rx u_xgmii2axis_rx (
        .clk             (clk),
        .inv_aresetn     (inv_aresetn),
        .xgmii_d_i       (xgmii_d),
        .xgmii_c_i       (xgmii_c),
        .m_axis_tdata_o  (m_axis_tdata),
        .m_axis_tkeep_o  (m_axis_tkeep),
        .m_axis_tvalid_o (m_axis_tvalid),
        .m_axis_tlast_o  (m_axis_tlast),
        .m_axis_tuser_o  (m_axis_tuser),
        .good_frames_o   (good_frames),
        .bad_frames_o    (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!inv_aresetn && m_axis_tvalid) begin
            cap_data.push_back(m_axis_tdata);
            cap_keep.push_back(m_axis_tkeep);
            cap_last.push_back(m_axis_tlast);
            cap_user.push_back(m_axis_tuser);
        end
    end

    // stream assertions are watched every cycle
    always @(negedge clk) begin
        if (u_xgmii2axis_rx.u_rx_assert.fail_count != 0) begin
            abort_run("a concurrent assertion on the stream outputs failed");
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 16'h0000);
    endfunction

    // one lfsr step per bit
    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic random_word(output xgmii_data_t w);
        logic [7:0] b;
        for (int l = 0; l < 8; l++) begin
            random_byte(b);
            w[8*l +: 8] = b;
        end
    endtask

    // reflected crc-32, lsb of each byte first
    function automatic crc_t crc_add_byte(input crc_t c, input logic [7:0] b);
        crc_t v;
        v = c;
        for (int i = 0; i < 8; i++) begin
            v = (v[0] ^ b[i]) ? ((v >> 1) ^ CRC_POLY_REFL) : (v >> 1);
        end
        return v;
    endfunction

    function automatic xgmii_data_t keep_mask(input xgmii_ctrl_t k);
        xgmii_data_t m;
        for (int l = 0; l < 8; l++) begin
            m[8*l +: 8] = {8{k[l]}};
        end
        return m;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Fail %s %s expected %h actual %h",
                                test, what, expected, actual));
        end
    endtask

    task automatic drive_word(input xgmii_data_t d, input xgmii_ctrl_t c);
        @(posedge clk);
        #2;
        xgmii_d = d;
        xgmii_c = c;
    endtask

    task automatic send_idle(input int n);
        repeat (n) drive_word({8{XGMII_IDLE}}, 8'hFF);
    endtask

    // ----------------------------------------
    // reference model and frame encoder
    // ----------------------------------------

    // cut: frame ends on an error word, so only the full words before it come out
    task automatic expect_frame(input logic [7:0] bytes_q[$], input int len,
                                input bit good, input bit cut);
        int          n_beats;
        int          n_keep;
        xgmii_data_t d;
        xgmii_ctrl_t k;
        n_beats = cut ? (bytes_q.size() / 8) : ((len + 7) / 8);
        for (int b = 0; b < n_beats; b++) begin
            n_keep = (cut || (len - 8*b) > 8) ? 8 : (len - 8*b);
            d = '0;
            k = '0;
            for (int l = 0; l < n_keep; l++) begin
                d[8*l +: 8] = bytes_q[8*b + l];
                k[l]        = 1'b1;
            end
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(b == n_beats - 1);
            exp_user.push_back(good && (b == n_beats - 1));
        end
        if (good) begin
            exp_good++;
        end else begin
            exp_bad++;
        end
    endtask

    task automatic send_frame(input int len, input bit flip_fcs, input bit err_term,
                              input int gap);
        logic [7:0]  bytes_q[$];
        logic [7:0]  b;
        crc_t        crc;
        xgmii_data_t d;
        xgmii_ctrl_t c;
        int          n;
        crc = CRC_PRESET;
        for (int i = 0; i < len; i++) begin
            random_byte(b);
            bytes_q.push_back(b);
            crc = crc_add_byte(crc, b);
        end
        // fcs is the inverted crc, low byte first
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            bytes_q.push_back(crc[8*i +: 8]);
        end
        if (flip_fcs) begin
            bytes_q[len] = bytes_q[len] ^ 8'h01;
        end
        expect_frame(bytes_q, len, !flip_fcs && !err_term, err_term);

        n = bytes_q.size();
        drive_word({XGMII_SFD, {6{XGMII_PREAMBLE}}, XGMII_START}, 8'h01);
        for (int w = 0; w <= n / 8; w++) begin
            for (int l = 0; l < 8; l++) begin
                if (8*w + l < n) begin
                    d[8*l +: 8] = bytes_q[8*w + l];
                    c[l]        = 1'b0;
                end else if (8*w + l == n) begin
                    d[8*l +: 8] = err_term ? XGMII_ERROR : XGMII_TERM;
                    c[l]        = 1'b1;
                end else begin
                    d[8*l +: 8] = XGMII_IDLE;
                    c[l]        = 1'b1;
                end
            end
            drive_word(d, c);
        end
        send_idle(gap);
    endtask

    // ----------------------------------------
    // capture and compare
    // ----------------------------------------

    task automatic wait_for_beats(input string test);
        int cycles;
        cycles = 0;
        while (cap_keep.size() < exp_keep.size()) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("%s: timed out waiting for stream beats", test));
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic compare_beats(input string test);
        xgmii_ctrl_t k;
        wait_for_beats(test);
        while (exp_keep.size() > 0) begin
            k = exp_keep.pop_front();
            check_value(test, "tkeep", k, cap_keep.pop_front());
            check_value(test, "tdata", exp_data.pop_front() & keep_mask(k),
                        cap_data.pop_front() & keep_mask(k));
            check_value(test, "tlast", exp_last.pop_front(), cap_last.pop_front());
            check_value(test, "tuser", exp_user.pop_front(), cap_user.pop_front());
        end
        check_value(test, "extra beats", 0, cap_keep.size());
        check_value(test, "good_frames", exp_good, good_frames);
        check_value(test, "bad_frames", exp_bad, bad_frames);
    endtask

    task automatic apply_reset(input string test);
        @(posedge clk);
        #2;
        inv_aresetn = 1'b1;
        xgmii_d     = {8{XGMII_IDLE}};
        xgmii_c     = 8'hFF;
        // the first reset edge already clears the stream and the counters
        @(posedge clk);
        @(negedge clk);
        check_value(test, "tvalid in reset", 0, m_axis_tvalid);
        check_value(test, "good_frames in reset", 0, good_frames);
        check_value(test, "bad_frames in reset", 0, bad_frames);
        repeat (6) @(posedge clk);
        @(posedge clk);
        #2;
        inv_aresetn = 1'b0;
        cap_data.delete();
        cap_keep.delete();
        cap_last.delete();
        cap_user.delete();
        exp_good = 0;
        exp_bad  = 0;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    // lengths 60 to 67 move the terminate through lanes 0 to 7
    task automatic term_lane_sweep();
        for (int len = 60; len <= 67; len++) begin
            send_frame(len, 1'b0, 1'b0, 4);
            compare_beats($sformatf("term_lane_%0d", (len + FCS_BYTES) % 8));
        end
    endtask

    task automatic bad_fcs_frame();
        send_frame(70, 1'b1, 1'b0, 4);
        compare_beats("bad_fcs");
    endtask

    task automatic error_terminate();
        send_frame(63, 1'b0, 1'b1, 4);
        send_frame(66, 1'b0, 1'b0, 4);
        compare_beats("error_terminate");
    endtask

    task automatic back_to_back_frames();
        send_frame(64, 1'b0, 1'b0, 1);
        send_frame(75, 1'b0, 1'b0, 1);
        send_frame(61, 1'b1, 1'b0, 1);
        send_frame(100, 1'b0, 1'b0, 1);
        send_frame(68, 1'b0, 1'b0, 1);
        compare_beats("back_to_back");
    endtask

    task automatic reset_mid_frame();
        xgmii_data_t w;
        drive_word({XGMII_SFD, {6{XGMII_PREAMBLE}}, XGMII_START}, 8'h01);
        for (int i = 0; i < 4; i++) begin
            random_word(w);
            drive_word(w, 8'h00);
        end
        apply_reset("reset_mid_frame");
        send_idle(2);
        send_frame(72, 1'b0, 1'b0, 4);
        compare_beats("reset_mid_frame");
    endtask

    initial begin
        inv_aresetn = 1'b1;
        xgmii_d     = {8{XGMII_IDLE}};
        xgmii_c     = 8'hFF;
        lfsr        = LFSR_SEED;
        exp_good    = 0;
        exp_bad     = 0;

        apply_reset("power_on");
        send_idle(4);
        term_lane_sweep();
        bad_fcs_frame();
        error_terminate();
        back_to_back_frames();
        reset_mid_frame();
        send_idle(4);

        if (u_xgmii2axis_rx.u_rx_assert.fail_count != 0) begin
            abort_run("concurrent assertions on the stream outputs failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* xgmii_rx.f */
design/xgmii_rx_pkg.sv
design/xgmii_ctrl_decode.sv
design/crc32_d64.sv
design/xgmii_rx_framer.sv
design/axis_rx_output.sv
design/xgmii2axis_rx.sv
verification/xgmii2axis_rx_assert.sv
verification/tb_xgmii2axis_rx.sv
